// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // major opcodes, full 7 bits so compressed encodings fall out as illegal
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam int CLASS_W = 3;
  localparam logic [CLASS_W-1:0] CLASS_ALU    = 3'd0;
  localparam logic [CLASS_W-1:0] CLASS_LUI    = 3'd1;
  localparam logic [CLASS_W-1:0] CLASS_AUIPC  = 3'd2;
  localparam logic [CLASS_W-1:0] CLASS_JAL    = 3'd3;
  localparam logic [CLASS_W-1:0] CLASS_JALR   = 3'd4;
  localparam logic [CLASS_W-1:0] CLASS_BRANCH = 3'd5;
  localparam logic [CLASS_W-1:0] CLASS_LOAD   = 3'd6;
  localparam logic [CLASS_W-1:0] CLASS_STORE  = 3'd7;

  localparam int ALU_OP_W = 4;
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

  // access size in funct3 of loads and stores
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // core fsm states
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_FETCH      = 3'd0;
  localparam logic [ST_W-1:0] ST_WAIT_INSTR = 3'd1;
  localparam logic [ST_W-1:0] ST_DECODE     = 3'd2;
  localparam logic [ST_W-1:0] ST_EXECUTE    = 3'd3;
  localparam logic [ST_W-1:0] ST_WAIT_DATA  = 3'd4;
  localparam logic [ST_W-1:0] ST_CHECK_PC   = 3'd5;
  localparam logic [ST_W-1:0] ST_WRITEBACK  = 3'd6;
  localparam logic [ST_W-1:0] ST_TRAP       = 3'd7;

  // r view for register and i-type fields, s view for store and branch
  typedef union packed {
    struct packed {
      union packed {
        logic [11:0] imm12;
        struct packed {
          logic [6:0] funct7;
          logic [4:0] rs2;
        } f;
      } hi;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
  } instr_word_t;

endpackage

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  instr_word_t               instr,
  output logic [CLASS_W-1:0]        op_class,
  output logic [ALU_OP_W-1:0]       alu_op,
  output logic                      use_imm,
  output logic [XLEN-1:0]           immediate,
  output logic [REG_ADDR_W-1:0]     rd,
  output logic [REG_ADDR_W-1:0]     rs1,
  output logic [REG_ADDR_W-1:0]     rs2,
  output logic [2:0]                funct3,
  output logic                      illegal
);

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [6:0]      funct7;

  function automatic logic [ALU_OP_W-1:0] f3_to_alu_op(input logic [2:0] f3, input logic alt);
    logic [ALU_OP_W-1:0] op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3 = instr.r.funct3;
  assign funct7 = instr.r.hi.f.funct7;
  assign rs1    = instr.r.rs1;
  assign rs2    = instr.r.hi.f.rs2;

  assign imm_i = {{20{instr[31]}}, instr.r.hi.imm12};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                  instr.s.imm_lo[4:1], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    op_class  = CLASS_ALU;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    immediate = imm_i;
    rd        = instr.r.rd;
    illegal   = 1'b0;
    case (instr.r.opcode)
      OPC_LUI: begin
        op_class  = CLASS_LUI;
        immediate = imm_u;
      end
      OPC_AUIPC: begin
        op_class  = CLASS_AUIPC;
        immediate = imm_u;
      end
      OPC_JAL: begin
        op_class  = CLASS_JAL;
        immediate = imm_j;
      end
      OPC_JALR: begin
        op_class = CLASS_JALR;
        illegal  = funct3 != 3'b000;
      end
      OPC_BRANCH: begin
        op_class  = CLASS_BRANCH;
        immediate = imm_b;
        rd        = '0;
        // eq/ne compare through the subtractor, the rest through slt
        case (funct3[2:1])
          2'b00:   alu_op = ALU_SUB;
          2'b10:   alu_op = ALU_SLT;
          2'b11:   alu_op = ALU_SLTU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        op_class = CLASS_LOAD;
        illegal  = !(funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
      end
      OPC_STORE: begin
        op_class  = CLASS_STORE;
        immediate = imm_s;
        rd        = '0;
        illegal   = !(funct3 inside {F3_B, F3_H, F3_W});
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        alu_op  = f3_to_alu_op(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3 == 3'b001) begin
          illegal = funct7 != 7'b0000000;
        end else if (funct3 == 3'b101) begin
          illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
        end
      end
      OPC_OP: begin
        alu_op = f3_to_alu_op(funct3, funct7[5]);
        if (funct7 == 7'b0100000) begin
          illegal = funct3 != 3'b000 && funct3 != 3'b101;
        end else begin
          illegal = funct7 != 7'b0000000;
        end
      end
      // ecall and ebreak are not supported and trap like any unknown word
      OPC_SYSTEM: illegal = 1'b1;
      default:    illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  logic                  we,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic [XLEN-1:0]       rd_data
);

  logic [XLEN-1:0] regs [2**REG_ADDR_W];

  // entry 0 is never written, its read is masked instead
  always_ff @(posedge clk) begin
    if (we && !reset && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [ALU_OP_W-1:0] alu_op,
  input  logic [XLEN-1:0]     a,
  input  logic [XLEN-1:0]     b,
  input  logic [2:0]          funct3,
  output logic [XLEN-1:0]     result,
  output logic                branch_taken
);

  logic [4:0] shamt;
  logic       cmp;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

  // sub gives equality through a zero result, slt/sltu give the less-than bit
  assign cmp = (alu_op == ALU_SUB) ? (result == '0) : result[0];

  always_comb begin
    case (funct3)
      3'b000, 3'b100, 3'b110: branch_taken = cmp;
      3'b001, 3'b101, 3'b111: branch_taken = !cmp;
      default:                branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu import rv_pkg::*; (
  input  logic [2:0]      funct3,
  input  logic            is_store,
  input  logic [1:0]      addr_low,
  input  logic [XLEN-1:0] store_data,
  input  logic [XLEN-1:0] rdata,
  output logic [3:0]      wstrb,
  output logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] load_data,
  output logic            misaligned
);

  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  always_comb begin
    case (funct3)
      F3_W:        misaligned = |addr_low;
      F3_H, F3_HU: misaligned = addr_low[0];
      default:     misaligned = 1'b0;
    endcase
  end

  // store lanes, data replicated so memory just honours the strobe
  always_comb begin
    case (funct3)
      F3_B: begin
        wstrb = 4'b0001 << addr_low;
        wdata = {4{store_data[7:0]}};
      end
      F3_H: begin
        wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
        wdata = {2{store_data[15:0]}};
      end
      default: begin
        wstrb = 4'b1111;
        wdata = store_data;
      end
    endcase
    if (!is_store) begin
      wstrb = 4'b0000;
    end
  end

  assign lane_b = rdata[{addr_low, 3'b000} +: 8];
  assign lane_h = addr_low[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3)
      F3_B:    load_data = {{24{lane_b[7]}}, lane_b};
      F3_BU:   load_data = {24'b0, lane_b};
      F3_H:    load_data = {{16{lane_h[15]}}, lane_h};
      F3_HU:   load_data = {16'b0, lane_h};
      default: load_data = rdata;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  output logic            mem_valid,
  output logic            mem_instr,
  input  logic            mem_ready,
  output logic [XLEN-1:0] mem_addr,
  output logic [XLEN-1:0] mem_wdata,
  output logic [3:0]      mem_wstrb,
  input  logic [XLEN-1:0] mem_rdata,
  output logic            trap
);

  logic [ST_W-1:0]       state;
  logic [XLEN-1:0]       pc, next_pc, pc_target, wb_data;
  instr_word_t           ir;

  logic [CLASS_W-1:0]    op_class;
  logic [ALU_OP_W-1:0]   alu_op;
  logic                  use_imm, illegal;
  logic [XLEN-1:0]       immediate;
  logic [REG_ADDR_W-1:0] rd, rs1, rs2;
  logic [2:0]            funct3;
  logic [XLEN-1:0]       rs1_data, rs2_data, alu_result, load_data, lsu_wdata;
  logic                  branch_taken, misaligned;
  logic [3:0]            lsu_wstrb;
  logic [XLEN-1:0]       ls_addr, jalr_sum, jump_target, pc_next_seq;

  rv_decoder u_decoder (
    .instr(ir), .op_class(op_class), .alu_op(alu_op), .use_imm(use_imm),
    .immediate(immediate), .rd(rd), .rs1(rs1), .rs2(rs2), .funct3(funct3),
    .illegal(illegal)
  );

  rv_regfile u_regfile (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .we(state == ST_WRITEBACK), .rd(rd), .rd_data(wb_data)
  );

  rv_alu u_alu (
    .alu_op(alu_op), .a(rs1_data), .b(use_imm ? immediate : rs2_data), .funct3(funct3),
    .result(alu_result), .branch_taken(branch_taken)
  );

  rv_lsu u_lsu (
    .funct3(funct3), .is_store(op_class == CLASS_STORE), .addr_low(ls_addr[1:0]),
    .store_data(rs2_data), .rdata(mem_rdata), .wstrb(lsu_wstrb), .wdata(lsu_wdata),
    .load_data(load_data), .misaligned(misaligned)
  );

  assign pc_next_seq = pc + XLEN'(4);
  assign ls_addr     = rs1_data + immediate;
  assign jalr_sum    = rs1_data + immediate;

  always_comb begin
    case (op_class)
      CLASS_JALR:   jump_target = {jalr_sum[XLEN-1:1], 1'b0};
      CLASS_BRANCH: jump_target = branch_taken ? pc + immediate : pc_next_seq;
      default:      jump_target = pc + immediate;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_FETCH;
      next_pc   <= RESET_PC;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= 4'b0000;
      trap      <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= 4'b0000;
          mem_addr  <= next_pc;
          state     <= ST_WAIT_INSTR;
        end
        ST_WAIT_INSTR: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            pc        <= mem_addr;
            ir        <= mem_rdata;
            state     <= ST_DECODE;
          end
        end
        ST_DECODE: state <= illegal ? ST_TRAP : ST_EXECUTE;
        ST_EXECUTE: begin
          next_pc <= pc_next_seq;
          wb_data <= pc_next_seq;
          state   <= ST_WRITEBACK;
          case (op_class)
            CLASS_ALU:   wb_data <= alu_result;
            CLASS_LUI:   wb_data <= immediate;
            CLASS_AUIPC: wb_data <= pc + immediate;
            CLASS_JAL, CLASS_JALR, CLASS_BRANCH: begin
              pc_target <= jump_target;
              state     <= ST_CHECK_PC;
            end
            default: begin
              // loads and stores share one word-aligned request
              if (misaligned) begin
                state <= ST_TRAP;
              end else begin
                mem_valid <= 1'b1;
                mem_instr <= 1'b0;
                mem_addr  <= {ls_addr[XLEN-1:2], 2'b00};
                mem_wstrb <= lsu_wstrb;
                mem_wdata <= lsu_wdata;
                state     <= ST_WAIT_DATA;
              end
            end
          endcase
        end
        ST_WAIT_DATA: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_wstrb <= 4'b0000;
            wb_data   <= load_data;
            state     <= (op_class == CLASS_LOAD) ? ST_WRITEBACK : ST_FETCH;
          end
        end
        ST_CHECK_PC: begin
          if (pc_target[1:0] != 2'b00) begin
            state <= ST_TRAP;
          end else begin
            next_pc <= pc_target;
            state   <= (op_class == CLASS_BRANCH) ? ST_FETCH : ST_WRITEBACK;
          end
        end
        ST_WRITEBACK: state <= ST_FETCH;
        default:      trap <= 1'b1;
      endcase
    end
  end

  // a pending request keeps its address and strobe until accepted
  assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wstrb));

  assert property (@(posedge clk) disable iff (reset) trap |=> trap);

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
  end

  always begin
    #HALF_PERIOD;
    clk = ~clk;
  end

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int N_TESTS = 50;
  localparam int MEM_WORDS = 1024;

  localparam int K_R = 0;
  localparam int K_I = 1;
  localparam int K_LUI = 2;
  localparam int K_AUIPC = 3;
  localparam int K_STORE = 4;
  localparam int K_LOAD = 5;
  localparam int K_BRANCH = 6;
  localparam int K_JAL = 7;
  localparam int K_JALR = 8;
  localparam int K_ILLEGAL = 9;
  localparam int K_MIS_LW = 10;
  localparam int K_MIS_JALR = 11;

  logic            clk, reset, mem_ready, trap;
  logic            mem_valid, mem_instr;
  logic [31:0]     mem_addr, mem_wdata, mem_rdata;
  logic [3:0]      mem_wstrb;

  logic [31:0]     mem [0:MEM_WORDS-1];
  logic [31:0]     prog [$];
  logic [31:0]     lcg_state;
  int              errors;
  int              n_entries;

  // test table
  string           t_name [N_TESTS];
  int              t_kind [N_TESTS];
  logic [2:0]      t_f3 [N_TESTS];
  int              t_mode [N_TESTS];
  logic [31:0]     t_a [N_TESTS];
  logic [31:0]     t_b [N_TESTS];

  // memory model state and store capture
  logic            busy, first_seen;
  logic [1:0]      wait_left;
  logic [31:0]     req_addr, st_addr, st_data, rnd;
  logic [3:0]      req_strb, st_strb;
  int              store_count;

  tb_clock u_clock (.clk(clk));

  rv_core UUT (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_instr(mem_instr),
    .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .trap(trap)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // reference arithmetic straight from the ISA rules
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, $signed(x) < $signed(y)};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      3'd7:    return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  // lui/addi pair, upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] t;
    t = v + 32'h800;
    emit(enc_u(OPC_LUI, rd, t[31:12]));
    emit(enc_i(OPC_OP_IMM, 3'd0, rd, rd, v[11:0]));
  endtask

  task automatic add_entry(input string nm, input int kind, input logic [2:0] f3,
                           input int mode);
    t_name[n_entries] = nm;
    t_kind[n_entries] = kind;
    t_f3[n_entries]   = f3;
    t_mode[n_entries] = mode;
    t_a[n_entries]    = lcg_next();
    t_b[n_entries]    = lcg_next();
    n_entries++;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[ERROR] %s: expected %08h, actual %08h", what, exp_v, act_v);
    errors++;
  endtask

  task automatic build_table();
    add_entry("add", K_R, 3'd0, 0);
    add_entry("sub", K_R, 3'd0, 1);
    add_entry("sll", K_R, 3'd1, 0);
    add_entry("slt", K_R, 3'd2, 0);
    add_entry("sltu", K_R, 3'd3, 0);
    add_entry("xor", K_R, 3'd4, 0);
    add_entry("srl", K_R, 3'd5, 0);
    add_entry("sra", K_R, 3'd5, 1);
    add_entry("or", K_R, 3'd6, 0);
    add_entry("and", K_R, 3'd7, 0);
    add_entry("addi", K_I, 3'd0, 0);
    add_entry("slti", K_I, 3'd2, 0);
    add_entry("sltiu", K_I, 3'd3, 0);
    add_entry("xori", K_I, 3'd4, 0);
    add_entry("ori", K_I, 3'd6, 0);
    add_entry("andi", K_I, 3'd7, 0);
    add_entry("slli", K_I, 3'd1, 0);
    add_entry("srli", K_I, 3'd5, 0);
    add_entry("srai", K_I, 3'd5, 1);
    add_entry("lui", K_LUI, 3'd0, 0);
    add_entry("auipc", K_AUIPC, 3'd0, 0);
    add_entry("sb_off0", K_STORE, F3_B, 0);
    add_entry("sb_off1", K_STORE, F3_B, 1);
    add_entry("sb_off2", K_STORE, F3_B, 2);
    add_entry("sb_off3", K_STORE, F3_B, 3);
    add_entry("sh_off0", K_STORE, F3_H, 0);
    add_entry("sh_off2", K_STORE, F3_H, 2);
    add_entry("sw", K_STORE, F3_W, 0);
    add_entry("lb_off0", K_LOAD, F3_B, 0);
    add_entry("lb_off3", K_LOAD, F3_B, 3);
    add_entry("lbu_off1", K_LOAD, F3_BU, 1);
    add_entry("lbu_off2", K_LOAD, F3_BU, 2);
    add_entry("lh_off0", K_LOAD, F3_H, 0);
    add_entry("lh_off2", K_LOAD, F3_H, 2);
    add_entry("lhu_off0", K_LOAD, F3_HU, 0);
    add_entry("lhu_off2", K_LOAD, F3_HU, 2);
    add_entry("beq_equal", K_BRANCH, 3'd0, 1);
    add_entry("beq_differ", K_BRANCH, 3'd0, 0);
    add_entry("bne_equal", K_BRANCH, 3'd1, 1);
    add_entry("bne_differ", K_BRANCH, 3'd1, 0);
    add_entry("blt", K_BRANCH, 3'd4, 0);
    add_entry("bge", K_BRANCH, 3'd5, 0);
    add_entry("bge_equal", K_BRANCH, 3'd5, 1);
    add_entry("bltu", K_BRANCH, 3'd6, 0);
    add_entry("bgeu", K_BRANCH, 3'd7, 0);
    add_entry("jal", K_JAL, 3'd0, 0);
    add_entry("jalr", K_JALR, 3'd0, 0);
    add_entry("illegal_word", K_ILLEGAL, 3'd0, 0);
    add_entry("misaligned_lw", K_MIS_LW, 3'd0, 0);
    add_entry("misaligned_jalr", K_MIS_JALR, 3'd0, 0);
  endtask

  task automatic run_entry(input int n);
    logic [31:0] a, b, x1v, x2v, exp_addr, exp_data;
    logic [3:0]  exp_strb;
    logic [11:0] imm;
    logic [2:0]  f3;
    int          off;
    logic        expect_store;
    off = t_mode[n];
    f3 = t_f3[n];
    a = t_a[n];
    b = t_b[n];
    x1v = a;
    x2v = b;
    expect_store = 1'b1;
    exp_addr = 32'h100;
    exp_strb = 4'b1111;
    exp_data = '0;
    prog.delete();
    case (t_kind[n])
      K_STORE:    x1v = 32'h200 + off;
      K_LOAD:     x1v = 32'h200;
      K_BRANCH:   x2v = (off != 0) ? a : b;
      K_JALR:     x1v = 32'd25;
      K_MIS_LW:   x1v = 32'h202;
      // a core that ignored the low bits would land on the sw at 0x14
      K_MIS_JALR: x1v = 32'h16;
      default:    ;
    endcase
    // operands land in x1 and x2, the instruction under test sits at 0x10
    load_const(5'd1, x1v);
    load_const(5'd2, x2v);
    case (t_kind[n])
      K_R: begin
        emit(enc_r(off[0] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
        exp_data = alu_ref(f3, off[0], a, b);
      end
      K_I: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {1'b0, off[0], 5'b0, b[4:0]};
        end else begin
          imm = b[11:0];
        end
        emit(enc_i(OPC_OP_IMM, f3, 5'd3, 5'd1, imm));
        exp_data = alu_ref(f3, off[0], a, sext12(imm));
      end
      K_LUI: begin
        emit(enc_u(OPC_LUI, 5'd3, a[31:12]));
        exp_data = {a[31:12], 12'b0};
      end
      K_AUIPC: begin
        emit(enc_u(OPC_AUIPC, 5'd3, a[31:12]));
        exp_data = 32'h10 + {a[31:12], 12'b0};
      end
      K_STORE: begin
        emit(enc_s(f3, 5'd1, 5'd2, 12'h000));
        exp_addr = 32'h200;
        if (f3 == F3_B) begin
          exp_strb = 4'b0001 << off[1:0];
          exp_data = {4{b[7:0]}};
        end else if (f3 == F3_H) begin
          exp_strb = off[1] ? 4'b1100 : 4'b0011;
          exp_data = {2{b[15:0]}};
        end else begin
          exp_data = b;
        end
      end
      K_LOAD: begin
        emit(enc_i(OPC_LOAD, f3, 5'd3, 5'd1, off[11:0]));
        case (f3)
          F3_B:    exp_data = sext12({{4{a[8*off+7]}}, a[8*off +: 8]});
          F3_BU:   exp_data = {24'b0, a[8*off +: 8]};
          F3_H:    exp_data = {{16{a[8*off+15]}}, a[8*off +: 16]};
          default: exp_data = {16'b0, a[8*off +: 16]};
        endcase
      end
      K_BRANCH: begin
        emit(enc_i(OPC_OP_IMM, 3'd0, 5'd3, 5'd0, 12'h010));
        emit(enc_b(f3, 5'd1, 5'd2, 13'd8));
        emit(enc_i(OPC_OP_IMM, 3'd0, 5'd3, 5'd3, 12'h001));
        exp_data = branch_ref(f3, x1v, x2v) ? 32'h10 : 32'h11;
      end
      K_JAL: begin
        emit(enc_j(5'd3, 21'd8));
        emit(enc_i(OPC_OP_IMM, 3'd0, 5'd3, 5'd0, 12'h000));
        exp_data = 32'h14;
      end
      K_JALR: begin
        emit(enc_i(OPC_JALR, 3'd0, 5'd3, 5'd1, 12'h000));
        emit(enc_i(OPC_OP_IMM, 3'd0, 5'd3, 5'd0, 12'h007));
        exp_data = 32'h14;
      end
      K_ILLEGAL: begin
        emit(32'h0);
        expect_store = 1'b0;
      end
      K_MIS_LW: begin
        emit(enc_i(OPC_LOAD, F3_W, 5'd3, 5'd1, 12'h000));
        expect_store = 1'b0;
      end
      default: begin
        emit(enc_i(OPC_JALR, 3'd0, 5'd3, 5'd1, 12'h000));
        expect_store = 1'b0;
      end
    endcase
    if (t_kind[n] != K_STORE) begin
      emit(enc_s(F3_W, 5'd0, 5'd3, 12'h100));
    end
    emit(32'h0);

    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = i * 32'h9e3779b9;
    end
    for (int i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
    end
    mem[32'h200 >> 2] = a;

    @(posedge clk);
    #1;
    reset = 1'b1;
    store_count = 0;
    first_seen = 1'b0;
    repeat (16) begin
      @(posedge clk);
      #1;
      if (mem_valid !== 1'b0 || trap !== 1'b0) begin
        $display("%s: mem_valid or trap not low during reset", t_name[n]);
        errors++;
      end
    end
    reset = 1'b0;

    while (trap !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    repeat (8) begin
      @(posedge clk);
      #1;
      if (mem_valid !== 1'b0) begin
        $display("%s: memory request issued after trap", t_name[n]);
        errors++;
      end
    end

    if (expect_store) begin
      if (store_count != 1) begin
        $display("%s: expected one store, saw %0d", t_name[n], store_count);
        errors++;
      end else begin
        if (st_addr !== exp_addr) begin
          report_mismatch({t_name[n], " address"}, exp_addr, st_addr);
        end
        if (st_strb !== exp_strb) begin
          report_mismatch({t_name[n], " strobe"}, {28'b0, exp_strb}, {28'b0, st_strb});
        end
        if (st_data !== exp_data) begin
          report_mismatch({t_name[n], " data"}, exp_data, st_data);
        end
      end
    end else if (store_count != 0) begin
      $display("%s: store seen after the trapping instruction", t_name[n]);
      errors++;
    end
  endtask

  // answers each request after 0 to 3 cycles
  always begin
    @(posedge clk);
    #1;
    if (reset || mem_ready) begin
      mem_ready = 1'b0;
      busy = 1'b0;
    end else if (mem_valid) begin
      if (!busy) begin
        busy = 1'b1;
        rnd = lcg_next();
        wait_left = rnd[17:16];
        req_addr = mem_addr;
        req_strb = mem_wstrb;
        if (!first_seen) begin
          first_seen = 1'b1;
          if (mem_instr !== 1'b1 || mem_addr !== RESET_PC) begin
            $display("first request after reset is not a fetch from the reset vector");
            errors++;
          end
        end
        if (!mem_instr && mem_addr[1:0] != 2'b00) begin
          $display("data request to unaligned address %08h", mem_addr);
          errors++;
        end
      end else if (mem_addr !== req_addr || mem_wstrb !== req_strb) begin
        $display("request changed address or strobe before it was accepted");
        errors++;
      end
      if (wait_left == 2'd0) begin
        mem_ready = 1'b1;
        mem_rdata = mem[mem_addr[11:2]];
        if (mem_wstrb != 4'b0000) begin
          for (int k = 0; k < 4; k++) begin
            if (mem_wstrb[k]) begin
              mem[mem_addr[11:2]][8*k +: 8] = mem_wdata[8*k +: 8];
            end
          end
          store_count++;
          st_addr = mem_addr;
          st_strb = mem_wstrb;
          st_data = mem_wdata;
        end
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

  initial begin : watchdog
    #(N_TESTS * 400 * CLK_PERIOD);
    $display("timeout: the run did not finish in the allowed time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    lcg_state = 32'd19;
    errors = 0;
    n_entries = 0;
    busy = 1'b0;
    first_seen = 1'b0;
    wait_left = 2'd0;
    store_count = 0;
    build_table();
    for (int i = 0; i < N_TESTS; i++) begin
      run_entry(i);
    end
    $display("%0d errors in %0d tests", errors, N_TESTS);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
sim/tb_clock.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -o sim_tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_rv_core)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
